// ==== src.f ====
+incdir+logic
logic/motor_pkg.sv
logic/bridge_ctrl_if.sv
logic/drive_cfg_regs.sv
logic/pwm_gen.sv
logic/h_bridge.sv
logic/motor_channel.sv
testbench/tb_motor_channel.sv

// ==== Bender.yml ====
package:
  name: motor_channel

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/motor_pkg.sv
      - logic/bridge_ctrl_if.sv
      - logic/drive_cfg_regs.sv
      - logic/pwm_gen.sv
      - logic/h_bridge.sv
      - logic/motor_channel.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/tb_motor_channel.sv

// ==== testbench/tb_motor_channel.sv ====
/*
 self-checking testbench of the motor drive channel
 applies a table of drive settings with steady duty 0 or full,
 checks the leg levels, the ext_enable drop latency and the
 high-cycle count of random duties
*/
`timescale 1ns/1ps
`include "motor_config.svh"

module tb_motor_channel;
	import motor_pkg::*;

	localparam int    period     = 1 << `PWM_WIDTH;            // PWM period in clocks
	localparam duty_t duty_full  = duty_t'(period);            // always-high duty
	localparam int    settle     = 2 * period + `ENA_SYNC_STAGES + 1;
	localparam int    max_cycles = 20000;                      // run budget

	// one stimulus row with expected legs for both PWM phases
	typedef struct packed {
		bridge_mode_t mode;
		motor_cmd_t   command;
		dwell_t       dwell;
		logic         swap;
		logic [1:0]   invert;
		logic         enable;
		logic         ext_en;
		duty_t        duty;
		logic         hi_1, hi_2; // legs while pwm is high
		logic         lo_1, lo_2; // legs while pwm is low
	} row_t;

	logic         clk, arst_n, cfg_load, cfg_swap, cfg_enable, ext_enable;
	motor_cmd_t   cfg_command;
	bridge_mode_t cfg_mode;
	dwell_t       cfg_dwell;
	logic [1:0]   cfg_invert;
	duty_t        cfg_duty;
	logic         bridge_1, bridge_2;

	row_t   rows[$];
	int     total_edges = 0;
	integer seed = 35231; // fixed seed for the duty draws

	motor_channel DUT (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "stopped at first failure");
	endtask

	// posedge wait bounded by the overall cycle budget
	task automatic tick(input int n);
		int done_edges;
		done_edges = 0;
		while (done_edges < n) begin
			@(posedge clk);
			done_edges++;
			total_edges++;
			if (total_edges > max_cycles) abort_run("timeout: run exceeded its cycle budget");
		end
	endtask

	task automatic check_legs(input logic exp_1, input logic exp_2);
		if (bridge_1 !== exp_1) begin
			$display("error at %0t: bridge_1 expected %b, got %b", $time, exp_1, bridge_1);
			abort_run("leg level mismatch");
		end
		if (bridge_2 !== exp_2) begin
			$display("error at %0t: bridge_2 expected %b, got %b", $time, exp_2, bridge_2);
			abort_run("leg level mismatch");
		end
	endtask

	task automatic check_high_count(input int exp_cnt, input int got_cnt);
		if (got_cnt !== exp_cnt) begin
			$display("error at %0t: bridge_1 high count expected %0d, got %0d",
				$time, exp_cnt, got_cnt);
			abort_run("duty count mismatch");
		end
	endtask

	function automatic row_t make_row(input bridge_mode_t mode, input motor_cmd_t command,
		input dwell_t dwell, input logic swap, input logic [1:0] invert, input logic enable,
		input logic ext_en, input duty_t duty, input logic hi_1, input logic hi_2,
		input logic lo_1, input logic lo_2);
		row_t r;
		r = {mode, command, dwell, swap, invert, enable, ext_en, duty, hi_1, hi_2, lo_1, lo_2};
		return r;
	endfunction

	task automatic add_row(input row_t r);
		rows.push_back(r);
	endtask

	// expected legs straight from the bridge tables
	task automatic build_table();
		// in1_in2 format under both dwells with duty 0 and full
		add_row(make_row(in1_in2, coast, coast_dwell, 0, 2'b00, 1, 1, 0, 0, 0, 0, 0));
		add_row(make_row(in1_in2, coast, brake_dwell, 0, 2'b00, 1, 1, duty_full, 0, 0, 0, 0));
		add_row(make_row(in1_in2, coast, brake_dwell, 0, 2'b00, 1, 1, 0, 0, 0, 0, 0));
		add_row(make_row(in1_in2, forward, coast_dwell, 0, 2'b00, 1, 1, 0, 1, 0, 0, 0));
		add_row(make_row(in1_in2, forward, coast_dwell, 0, 2'b00, 1, 1, duty_full, 1, 0, 0, 0));
		add_row(make_row(in1_in2, forward, brake_dwell, 0, 2'b00, 1, 1, 0, 1, 0, 1, 1));
		add_row(make_row(in1_in2, forward, brake_dwell, 0, 2'b00, 1, 1, duty_full, 1, 0, 1, 1));
		add_row(make_row(in1_in2, backward, coast_dwell, 0, 2'b00, 1, 1, 0, 1, 1, 1, 0));
		add_row(make_row(in1_in2, backward, coast_dwell, 0, 2'b00, 1, 1, duty_full, 1, 1, 1, 0));
		add_row(make_row(in1_in2, backward, brake_dwell, 0, 2'b00, 1, 1, 0, 0, 1, 1, 1));
		add_row(make_row(in1_in2, backward, brake_dwell, 0, 2'b00, 1, 1, duty_full, 0, 1, 1, 1));
		add_row(make_row(in1_in2, brake, coast_dwell, 0, 2'b00, 1, 1, duty_full, 1, 1, 1, 1));
		add_row(make_row(in1_in2, brake, brake_dwell, 0, 2'b00, 1, 1, 0, 1, 1, 1, 1));
		add_row(make_row(in1_in2, brake, brake_dwell, 0, 2'b00, 1, 1, duty_full, 1, 1, 1, 1));
		add_row(make_row(in1_in2, coast, coast_dwell, 0, 2'b00, 1, 1, duty_full, 0, 0, 0, 0));
		add_row(make_row(in1_in2, brake, coast_dwell, 0, 2'b00, 1, 1, 0, 1, 1, 1, 1));
		// pwm_dir format where leg 2 carries the direction level
		add_row(make_row(pwm_dir, forward, coast_dwell, 0, 2'b00, 1, 1, 0, 1, 1, 0, 1));
		add_row(make_row(pwm_dir, forward, coast_dwell, 0, 2'b00, 1, 1, duty_full, 1, 1, 0, 1));
		add_row(make_row(pwm_dir, backward, coast_dwell, 0, 2'b00, 1, 1, 0, 1, 0, 0, 0));
		add_row(make_row(pwm_dir, backward, coast_dwell, 0, 2'b00, 1, 1, duty_full, 1, 0, 0, 0));
		add_row(make_row(pwm_dir, coast, coast_dwell, 0, 2'b00, 1, 1, duty_full, 0, 0, 0, 0));
		add_row(make_row(pwm_dir, brake, coast_dwell, 0, 2'b00, 1, 1, 0, 1, 1, 1, 1));
		add_row(make_row(pwm_dir, motor_cmd_t'(3'd5), coast_dwell, 0, 2'b00, 1, 1, duty_full,
			0, 0, 0, 0)); // illegal code idles
		// swap then per-leg invert then the enable gate
		add_row(make_row(pwm_dir, forward, coast_dwell, 1, 2'b00, 1, 1, 0, 1, 1, 1, 0));
		add_row(make_row(pwm_dir, forward, coast_dwell, 0, 2'b01, 1, 1, 0, 0, 1, 1, 1));
		add_row(make_row(pwm_dir, forward, coast_dwell, 0, 2'b10, 1, 1, 0, 1, 0, 0, 0));
		add_row(make_row(pwm_dir, forward, coast_dwell, 1, 2'b01, 1, 1, 0, 0, 1, 0, 0));
		add_row(make_row(pwm_dir, coast, coast_dwell, 0, 2'b11, 0, 1, 0, 0, 0, 0, 0)); // invert alone gives 1/1
		add_row(make_row(pwm_dir, brake, coast_dwell, 0, 2'b00, 1, 0, duty_full, 0, 0, 0, 0));
	endtask

	// load one row with a single-cycle strobe
	task automatic apply_row(input row_t r);
		tick(1);
		cfg_mode    <= r.mode;
		cfg_command <= r.command;
		cfg_dwell   <= r.dwell;
		cfg_swap    <= r.swap;
		cfg_invert  <= r.invert;
		cfg_enable  <= r.enable;
		cfg_duty    <= r.duty;
		ext_enable  <= r.ext_en;
		cfg_load    <= 1'b1;
		tick(1);
		cfg_load    <= 1'b0;
	endtask

	// steady legs over one whole PWM period sampled on negedges
	task automatic check_period(input logic exp_1, input logic exp_2);
		for (int i = 0; i < period; i++) begin
			@(negedge clk);
			check_legs(exp_1, exp_2);
		end
	endtask

	task automatic count_high(output int cnt);
		cnt = 0;
		for (int i = 0; i < period; i++) begin
			@(negedge clk);
			if (bridge_1 === 1'b1) cnt++;
		end
	endtask

	initial begin
		int    waited;
		int    cnt;
		duty_t d;
		arst_n      = 1'b0;
		cfg_load    = 1'b0;
		cfg_command = coast;
		cfg_mode    = pwm_dir;
		cfg_dwell   = coast_dwell;
		cfg_swap    = 1'b0;
		cfg_invert  = 2'b00;
		cfg_enable  = 1'b0;
		cfg_duty    = '0;
		ext_enable  = 1'b0;
		build_table();
		tick(4);
		arst_n <= 1'b1;
		tick(2);
		check_period(1'b0, 1'b0); // reset state before any load

		foreach (rows[i]) begin
			apply_row(rows[i]);
			tick(settle);
			if (rows[i].duty == duty_full) check_period(rows[i].hi_1, rows[i].hi_2);
			else check_period(rows[i].lo_1, rows[i].lo_2);
		end

		// pin drop must idle the legs within the synchronizer latency
		apply_row(make_row(pwm_dir, brake, coast_dwell, 0, 2'b00, 1, 1, 0, 1, 1, 1, 1));
		tick(settle);
		check_period(1'b1, 1'b1);
		tick(1);
		ext_enable <= 1'b0;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while ((bridge_1 || bridge_2) && waited < `ENA_SYNC_STAGES + 1);
		check_legs(1'b0, 1'b0);

		// leg 1 high count per period for random duties
		for (int k = 0; k < 6; k++) begin
			d = duty_t'($unsigned($random(seed)) % (period + 1));
			apply_row(make_row(pwm_dir, forward, coast_dwell, 0, 2'b00, 1, 1, d, 1, 1, 0, 1));
			tick(settle);
			count_high(cnt);
			check_high_count(int'(d), cnt);
		end

		$display("No errors");
		$finish;
	end

endmodule

// ==== logic/motor_channel.sv ====
/*
 single DC motor drive channel
 config registers with enable synchronizer, PWM generator
 and the H-bridge output logic, plain ports at the boundary
*/
`timescale 1ns/1ps

module motor_channel (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    cfg_load,
	input  motor_pkg::motor_cmd_t   cfg_command,
	input  motor_pkg::bridge_mode_t cfg_mode,
	input  motor_pkg::dwell_t       cfg_dwell,
	input  logic                    cfg_swap,
	input  logic [1:0]              cfg_invert,
	input  logic                    cfg_enable,
	input  motor_pkg::duty_t        cfg_duty,
	input  logic                    ext_enable,
	output logic                    bridge_1,
	output logic                    bridge_2
);
	import motor_pkg::*;

	duty_t duty; // latched duty to the generator
	logic  pwm;  // generator output to the bridge

	bridge_ctrl_if ctrl_bus (); // latched controls

	drive_cfg_regs u_regs (
		.clk         (clk),
		.arst_n      (arst_n),
		.cfg_load    (cfg_load),
		.cfg_command (cfg_command),
		.cfg_mode    (cfg_mode),
		.cfg_dwell   (cfg_dwell),
		.cfg_swap    (cfg_swap),
		.cfg_invert  (cfg_invert),
		.cfg_enable  (cfg_enable),
		.cfg_duty    (cfg_duty),
		.ext_enable  (ext_enable),
		.duty        (duty),
		.ctrl        (ctrl_bus.regs)
	);

	pwm_gen u_pwm (
		.clk    (clk),
		.arst_n (arst_n),
		.duty   (duty),
		.pwm    (pwm)
	);

	h_bridge u_bridge (
		.pwm      (pwm),
		.ctrl     (ctrl_bus.bridge),
		.bridge_1 (bridge_1),
		.bridge_2 (bridge_2)
	);

endmodule

// ==== logic/h_bridge.sv ====
/*
 H-bridge output logic
 turns command, format, dwell and the PWM level into the
 two leg levels, then applies swap, per-leg invert and
 the enable gate, purely combinational
*/
`timescale 1ns/1ps

module h_bridge (
	input  logic         pwm,      // basic PWM waveform
	bridge_ctrl_if.bridge ctrl,    // latched controls
	output logic         bridge_1, // leg 1 drive
	output logic         bridge_2  // leg 2 drive
);
	import motor_pkg::*;

	logic raw_1, raw_2;       // legs before post processing
	logic swp_1, swp_2;       // after the swap
	logic inv_1, inv_2;       // after the invert

	// raw leg levels from format, command and dwell
	always_comb begin
		raw_1 = 1'b0; // illegal command or mode stays 0/0
		raw_2 = 1'b0;
		case (ctrl.mode)
			in1_in2: begin
				case (ctrl.command)
					coast: begin
						raw_1 = 1'b0;
						raw_2 = 1'b0;
					end
					forward: begin
						raw_1 = (ctrl.dwell == brake_dwell) ? 1'b1 : pwm;
						raw_2 = (ctrl.dwell == brake_dwell) ? !pwm : 1'b0; // off-time shorts low side
					end
					backward: begin
						raw_1 = (ctrl.dwell == brake_dwell) ? !pwm : 1'b1;
						raw_2 = (ctrl.dwell == brake_dwell) ? 1'b1 : pwm;
					end
					brake: begin
						raw_1 = 1'b1;
						raw_2 = 1'b1;
					end
					default: begin
						raw_1 = 1'b0;
						raw_2 = 1'b0;
					end
				endcase
			end
			pwm_dir: begin
				case (ctrl.command)
					coast: begin
						raw_1 = 1'b0;
						raw_2 = 1'b0;
					end
					forward: begin
						raw_1 = pwm;
						raw_2 = dir_fwd; // direction level on leg 2
					end
					backward: begin
						raw_1 = pwm;
						raw_2 = dir_bwd;
					end
					brake: begin
						raw_1 = 1'b1;
						raw_2 = 1'b1;
					end
					default: begin
						raw_1 = 1'b0;
						raw_2 = 1'b0;
					end
				endcase
			end
			default: begin
				raw_1 = 1'b0;
				raw_2 = 1'b0;
			end
		endcase
	end

	// an undefined command must never energize the bridge
	always_comb begin
		if (!(ctrl.command inside {coast, forward, backward, brake})) begin
			illegal_cmd_idle: assert final (!raw_1 && !raw_2)
				else $error("h_bridge: legs active on illegal command %0d", ctrl.command);
		end
	end

	// post processing order is swap, invert, enable
	assign swp_1 = ctrl.swap ? raw_2 : raw_1;
	assign swp_2 = ctrl.swap ? raw_1 : raw_2;
	assign inv_1 = swp_1 ^ ctrl.invert[0];
	assign inv_2 = swp_2 ^ ctrl.invert[1];

	assign bridge_1 = ctrl.int_enable & inv_1; // disabled wins over invert
	assign bridge_2 = ctrl.int_enable & inv_2;

endmodule

// ==== logic/pwm_gen.sv ====
/*
 free-running PWM generator
 period counter of 2^PWM_WIDTH clocks compared against a
 shadow duty that is reloaded only at the period wrap,
 so every period holds exactly duty high cycles
*/
`timescale 1ns/1ps
`include "motor_config.svh"

module pwm_gen (
	input  logic             clk,
	input  logic             arst_n,
	input  motor_pkg::duty_t duty,  // latched duty from the config block
	output logic             pwm    // registered level
);
	import motor_pkg::*;

	localparam duty_t duty_full = duty_t'(2 ** `PWM_WIDTH); // always-high duty

	logic [`PWM_WIDTH-1:0] cnt;     // period counter
	duty_t                 duty_sh; // duty in force for this period
	logic                  wrap;    // last count of the period

	assign wrap = (cnt == '1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1; // wraps naturally to 0
		end
	end

	// new duty only taken over on the wrap
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			duty_sh <= '0;
		end else if (wrap) begin
			duty_sh <= duty;
		end
	end

	// compare registered so the output is glitch-free
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pwm <= 1'b0;
		end else begin
			pwm <= ({1'b0, cnt} < duty_sh); // count 0..duty-1 gives high
		end
	end

	// duty beyond a full period has no meaning
	duty_in_range: assert property (@(posedge clk) disable iff (!arst_n)
		duty_sh <= duty_full)
		else $error("pwm_gen: shadow duty %0d above full scale", duty_sh);

endmodule

// ==== logic/drive_cfg_regs.sv ====
/*
 drive configuration registers
 latches command, format, dwell, swap, invert, enable and duty
 on a one-cycle load strobe, and brings the asynchronous
 ext_enable pin into the clock domain to form int_enable
*/
`timescale 1ns/1ps
`include "motor_config.svh"

module drive_cfg_regs (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   cfg_load,    // one-cycle strobe
	input  motor_pkg::motor_cmd_t  cfg_command,
	input  motor_pkg::bridge_mode_t cfg_mode,
	input  motor_pkg::dwell_t      cfg_dwell,
	input  logic                   cfg_swap,
	input  logic [1:0]             cfg_invert,
	input  logic                   cfg_enable,
	input  motor_pkg::duty_t       cfg_duty,
	input  logic                   ext_enable,  // asynchronous pin
	output motor_pkg::duty_t       duty,        // to the PWM generator
	bridge_ctrl_if.regs            ctrl
);
	import motor_pkg::*;

	motor_cmd_t   command_q;
	bridge_mode_t mode_q;
	dwell_t       dwell_q;
	logic         swap_q;
	logic [1:0]   invert_q;
	logic         enable_q;
	duty_t        duty_q;

	logic [`ENA_SYNC_STAGES-1:0] ena_sync; // bit 0 faces the pin

	// config registers, written only under the strobe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			command_q <= coast;
			mode_q    <= pwm_dir;
			dwell_q   <= coast_dwell;
			swap_q    <= 1'b0;
			invert_q  <= 2'b00;
			enable_q  <= 1'b0; // keeps int_enable low out of reset
			duty_q    <= '0;
		end else if (cfg_load) begin
			command_q <= cfg_command;
			mode_q    <= cfg_mode;
			dwell_q   <= cfg_dwell;
			swap_q    <= cfg_swap;
			invert_q  <= cfg_invert;
			enable_q  <= cfg_enable;
			duty_q    <= cfg_duty;
		end
	end

	// ext_enable synchronizer chain
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ena_sync <= '0;
		end else begin
			ena_sync[0] <= ext_enable;
			for (int i = 1; i < `ENA_SYNC_STAGES; i++) begin
				ena_sync[i] <= ena_sync[i-1]; // one stage per clock
			end
		end
	end

	assign ctrl.command    = command_q;
	assign ctrl.mode       = mode_q;
	assign ctrl.dwell      = dwell_q;
	assign ctrl.swap       = swap_q;
	assign ctrl.invert     = invert_q;
	assign ctrl.int_enable = enable_q & ena_sync[`ENA_SYNC_STAGES-1]; // both must agree
	assign duty            = duty_q;

	// a floating strobe would corrupt the whole config
	cfg_load_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown(cfg_load))
		else $error("drive_cfg_regs: cfg_load unknown");

endmodule

// ==== logic/bridge_ctrl_if.sv ====
/*
 bridge control bundle
 latched drive settings and the gated enable,
 driven by the config registers and read by the H-bridge
*/
`timescale 1ns/1ps

interface bridge_ctrl_if;
	import motor_pkg::*;

	motor_cmd_t   command;    // coast, forward, backward, brake
	bridge_mode_t mode;       // output format
	dwell_t       dwell;      // off-time style in in1_in2
	logic         swap;       // exchange the legs
	logic [1:0]   invert;     // bit 0 leg 1, bit 1 leg 2
	logic         int_enable; // latched enable and synced pin

	// register block side
	modport regs (
		output command, mode, dwell, swap, invert, int_enable
	);

	// bridge side
	modport bridge (
		input command, mode, dwell, swap, invert, int_enable
	);

endinterface

// ==== logic/motor_pkg.sv ====
/*
 motor channel shared types
 command, bridge output format, PWM dwell style,
 direction level and the PWM duty word
*/
`include "motor_config.svh"

package motor_pkg;

	// motor commands, codes 4..7 are illegal and give 0/0
	typedef enum logic [2:0] {
		coast    = 3'd0,
		forward  = 3'd1,
		backward = 3'd2,
		brake    = 3'd3
	} motor_cmd_t;

	// H-bridge output format
	typedef enum logic [1:0] {
		pwm_dir = 2'd0, // PWM on leg 1 plus direction on leg 2
		in1_in2 = 2'd1  // two-input format
	} bridge_mode_t;

	// what the PWM off-time does in in1_in2 format
	typedef enum logic {coast_dwell = 1'b0, brake_dwell = 1'b1} dwell_t;

	typedef enum logic {dir_bwd = 1'b0, dir_fwd = 1'b1} dir_t; // leg 2 level in pwm_dir

	// one extra bit so duty can reach a full period (always high)
	typedef logic [`PWM_WIDTH:0] duty_t;

endpackage

// ==== logic/motor_config.svh ====
/*
 motor drive channel build parameters
 PWM counter width sets the PWM period of 2^width clocks
 and the synchronizer depth sets the ext_enable latency
*/
`ifndef MOTOR_CONFIG_SVH
`define MOTOR_CONFIG_SVH

// counter width, 4 gives a 16 clock period
`define PWM_WIDTH 4

// flops between the ext_enable pin and the bridge gate
`define ENA_SYNC_STAGES 2

`endif
